/* all.f */
+incdir+sim
verilog/epd_pkg.sv
verilog/dither_csr.sv
verilog/frame_sequencer.sv
verilog/scan_counter.sv
verilog/bayer_dithering.sv
verilog/epd_dither_top.sv
sim/tb_epd_dither.sv

/* Makefile */
# Verilator build for the e-paper dither stage

VERILATOR ?= verilator
TOP       := tb_epd_dither
FILELIST  := all.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# A $fatal in the testbench gives a non-zero exit status
test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_apb_tasks.svh */
//////////////////////////////////////////////////
// APB master tasks for the dither testbench
// Register write, register read and read-compare
//////////////////////////////////////////////////

// Setup phase on the current edge, access phase on the next one
task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
                         input logic exp_err);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    assert (pready) else abort_run("pready was low in a write access phase");
    assert (pslverr == exp_err) else report_mismatch("pslverr", 32'(pslverr), 32'(exp_err));
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
endtask

task automatic read_reg(input logic [11:0] addr, output logic [31:0] data,
                        input logic exp_err);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    data = prdata;
    assert (pready) else abort_run("pready was low in a read access phase");
    assert (pslverr == exp_err) else report_mismatch("pslverr", 32'(pslverr), 32'(exp_err));
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic check_reg(input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    read_reg(addr, data, 1'b0);
    assert (data == exp) else report_mismatch($sformatf("prdata@%h", addr), data, exp);
endtask

/* sim/tb_epd_dither.sv */
//////////////////////////////////////////////////
// Testbench for the e-paper dither top level
// Clock, reset, APB and pixel stimulus
// Reference model with a queue of expected groups
// Handshake, framing and hold assertions, timeout
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_epd_dither;
    import epd_pkg::*;

    // Five frames of 12 groups plus register traffic stay far below this
    localparam int max_cycles = 4000;
    localparam int dither_idx [16] = '{0, 8, 2, 10, 12, 4, 14, 6, 3, 11, 1, 9, 15, 7, 13, 5};

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        pix_valid;
    logic [31:0] pix_data;
    logic        pix_ready;
    logic        out_valid;
    logic [15:0] out_data;
    logic        out_line_end;
    logic        out_frame_end;
    logic        out_ready = 1'b1;

    // Model state, written by the test sequence while no frame runs
    logic        cur_mode;
    logic [7:0]  cur_bias;
    logic [9:0]  frm_w;
    logic [9:0]  frm_h;
    logic        stall_en;
    logic [7:0]  frame_cnt_exp;
    int          frame_target;

    logic [17:0] exp_q[$];
    logic [9:0]  grp_idx;
    logic [9:0]  line_idx;
    int          acc_total;
    int          cycles;
    logic        stalled;
    logic [15:0] held_data;
    logic [1:0]  held_marks;
    logic        line_gap_acc;

    epd_dither_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .pix_valid     (pix_valid),
        .pix_data      (pix_data),
        .pix_ready     (pix_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_line_end  (out_line_end),
        .out_frame_end (out_frame_end),
        .out_ready     (out_ready)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    `include "tb_apb_tasks.svh"

    // Expected four levels of one group, lane 0 in the top nibble
    function automatic logic [15:0] dither_ref(input logic [31:0] pix, input logic [7:0] b,
                                               input logic bayer_on, input int row);
        logic [15:0] res;
        int level;
        int v;
        for (int k = 0; k < 4; k++) begin
            level = (int'(pix[31-8*k -: 8]) + int'(b)) >> 4;
            v = bayer_on ? level + dither_idx[row*4+k] - 8 : level;
            if (v < 0) begin
                v = 0;
            end else if (v > 15) begin
                v = 15;
            end
            res[15-4*k -: 4] = v[3:0];
        end
        return res;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            abort_run("the run exceeded the cycle limit");
        end
    end

    always @(posedge clk) begin
        if (stall_en) begin
            out_ready <= ($urandom % 3) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Reference model, one entry per accepted group, popped per output handshake
    always @(posedge clk) begin
        logic [17:0] expected;
        if (!rst_n) begin
            grp_idx   <= '0;
            line_idx  <= '0;
            acc_total <= 0;
        end else begin
            if (pix_valid && pix_ready) begin
                exp_q.push_back({grp_idx == frm_w, (grp_idx == frm_w) && (line_idx == frm_h),
                                 dither_ref(pix_data, cur_bias, cur_mode, int'(line_idx[1:0]))});
                acc_total <= acc_total + 1;
                if (grp_idx == frm_w) begin
                    grp_idx  <= '0;
                    line_idx <= (line_idx == frm_h) ? '0 : line_idx + 10'd1;
                end else begin
                    grp_idx <= grp_idx + 10'd1;
                end
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0)
                    else abort_run("an output group came with none expected");
                expected = exp_q.pop_front();
                assert (out_data == expected[15:0])
                    else report_mismatch("out_data", 32'(out_data), 32'(expected[15:0]));
                assert (out_line_end == expected[17])
                    else report_mismatch("out_line_end", 32'(out_line_end), 32'(expected[17]));
                assert (out_frame_end == expected[16])
                    else report_mismatch("out_frame_end", 32'(out_frame_end), 32'(expected[16]));
            end
        end
    end

    // Output must not move while the sink stalls
    always @(posedge clk) begin
        if (rst_n && stalled) begin
            assert (out_valid) else abort_run("out_valid dropped while out_ready was low");
            assert (out_data == held_data)
                else report_mismatch("out_data", 32'(out_data), 32'(held_data));
            assert ({out_line_end, out_frame_end} == held_marks)
                else report_mismatch("markers", 32'({out_line_end, out_frame_end}), 32'(held_marks));
        end
        stalled    <= out_valid && !out_ready;
        held_data  <= out_data;
        held_marks <= {out_line_end, out_frame_end};
    end

    assign line_gap_acc = pix_valid && pix_ready && (grp_idx == frm_w) && (line_idx != frm_h);

    gap_low: assert property (@(posedge clk) disable iff (!rst_n) line_gap_acc |=> !pix_ready)
        else abort_run("pix_ready stayed high after the last group of a line");
    gap_one: assert property (@(posedge clk) disable iff (!rst_n)
        $past(line_gap_acc, 2) |-> (pix_ready == (!out_valid || out_ready)))
        else abort_run("the line gap lasted longer than one cycle");
    marks_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> !(out_line_end || out_frame_end))
        else abort_run("a marker was set without out_valid");
    frame_mark: assert property (@(posedge clk) disable iff (!rst_n)
        out_frame_end |-> out_line_end)
        else abort_run("out_frame_end came without out_line_end");
    busy_held: assert property (@(posedge clk) disable iff (!rst_n)
        (acc_total != frame_target) |-> uut.busy)
        else abort_run("busy dropped before the last group of the frame");

    task automatic send_groups(input int n);
        int sent;
        sent = 0;
        pix_valid <= 1'b1;
        pix_data  <= $urandom;
        while (sent < n) begin
            @(posedge clk);
            if (pix_valid && pix_ready) begin
                sent++;
                pix_data <= $urandom;
            end
        end
        pix_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        st = 32'h1;
        while (st[0]) begin
            read_reg(addr_status, st, 1'b0);
        end
    endtask

    // One frame from start to drained output, optionally with a start while busy
    task automatic run_frame(input logic bayer_on, input logic restart);
        logic [31:0] st;
        int groups;
        int first;
        groups = (int'(frm_w) + 1) * (int'(frm_h) + 1);
        first = groups / 2 + 1;
        cur_mode = bayer_on;
        write_reg(addr_ctrl, {30'd0, bayer_on, 1'b1}, 1'b0);
        read_reg(addr_status, st, 1'b0);
        assert (st[0]) else abort_run("busy did not rise after start");
        frame_target <= acc_total + groups;
        if (restart) begin
            // The second start lands mid-line, where cleared counters would show up
            send_groups(first);
            write_reg(addr_ctrl, {30'd0, bayer_on, 1'b1}, 1'b0);
            send_groups(groups - first);
        end else begin
            send_groups(groups);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        wait_idle();
        frame_cnt_exp = frame_cnt_exp + 8'd1;
        check_reg(addr_status, {16'd0, frame_cnt_exp, 8'd0});
    endtask

    initial begin
        logic [31:0] rd;
        void'($urandom(38));
        rst_n         = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        pix_valid     = 1'b0;
        pix_data      = '0;
        cur_mode      = 1'b0;
        cur_bias      = 8'd10;
        frm_w         = '0;
        frm_h         = '0;
        stall_en      = 1'b0;
        frame_cnt_exp = '0;
        frame_target  = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!pix_ready && !out_valid && !pslverr && !out_line_end && !out_frame_end)
            else abort_run("an output was not low after reset");

        // Defaults, read-back and bus errors
        check_reg(addr_ctrl, 32'h0);
        check_reg(addr_bias, 32'd10);
        check_reg(addr_width, 32'h0);
        check_reg(addr_height, 32'h0);
        check_reg(addr_status, 32'h0);
        write_reg(addr_bias, 32'h5A, 1'b0);
        check_reg(addr_bias, 32'h5A);
        write_reg(addr_ctrl, 32'h2, 1'b0);
        check_reg(addr_ctrl, 32'h2);
        write_reg(addr_ctrl, 32'h0, 1'b0);
        write_reg(12'h014, 32'h1, 1'b1);
        read_reg(12'h014, rd, 1'b1);
        assert (rd == 32'h0) else report_mismatch("prdata", rd, 32'h0);
        write_reg(addr_status, 32'hFF, 1'b1);
        check_reg(addr_status, 32'h0);

        // Four groups per line and three lines
        write_reg(addr_width, 32'd3, 1'b0);
        write_reg(addr_height, 32'd2, 1'b0);
        check_reg(addr_width, 32'd3);
        check_reg(addr_height, 32'd2);
        frm_w = 10'd3;
        frm_h = 10'd2;
        write_reg(addr_bias, 32'd10, 1'b0);
        cur_bias = 8'd10;
        run_frame(1'b0, 1'b0);

        stall_en <= 1'b1;
        run_frame(1'b1, 1'b0);
        write_reg(addr_bias, 32'h33, 1'b0);
        cur_bias = 8'h33;
        check_reg(addr_bias, 32'h33);
        run_frame(1'b1, 1'b0);

        // Back-to-back frames, the first with a start written while busy
        run_frame(1'b1, 1'b1);
        run_frame(1'b1, 1'b0);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* verilog/epd_dither_top.sv */
//////////////////////////////////////////////////
// Top level of the e-paper dither stage
// APB registers, frame FSM, position counters
// and the dither datapath
//////////////////////////////////////////////////
`timescale 1ns/1ps

module epd_dither_top (
    input  logic        clk,
    input  logic        rst_n,
    // APB slave
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // Grey pixel input, four lanes of 8 bits
    input  logic        pix_valid,
    input  logic [31:0] pix_data,
    output logic        pix_ready,
    // Dithered output, four lanes of 4 bits
    output logic        out_valid,
    output logic [15:0] out_data,
    output logic        out_line_end,
    output logic        out_frame_end,
    input  logic        out_ready
);
    import epd_pkg::*;

    logic             start;
    dither_mode_e     mode;
    logic [7:0]       bias;
    logic [dim_w-1:0] width;
    logic [dim_w-1:0] height;
    logic             busy;
    logic             frame_done;
    logic             accept;
    logic             stage_ready;
    logic [1:0]       y_phase;
    logic             line_last;
    logic             frame_last;

    dither_csr u_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .frame_done (frame_done),
        .start      (start),
        .mode       (mode),
        .bias       (bias),
        .width      (width),
        .height     (height)
    );

    frame_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .pix_valid   (pix_valid),
        .stage_ready (stage_ready),
        .line_last   (line_last),
        .frame_last  (frame_last),
        .pix_ready   (pix_ready),
        .accept      (accept),
        .busy        (busy),
        .frame_done  (frame_done)
    );

    scan_counter u_scan (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .accept     (accept),
        .width      (width),
        .height     (height),
        .y_phase    (y_phase),
        .line_last  (line_last),
        .frame_last (frame_last)
    );

    bayer_dithering u_dither (
        .clk           (clk),
        .rst_n         (rst_n),
        .accept        (accept),
        .pix_data      (pix_data),
        .mode          (mode),
        .bias          (bias),
        .y_phase       (y_phase),
        .line_last     (line_last),
        .frame_last    (frame_last),
        .out_ready     (out_ready),
        .stage_ready   (stage_ready),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_line_end  (out_line_end),
        .out_frame_end (out_frame_end)
    );

endmodule

/* verilog/bayer_dithering.sv */
//////////////////////////////////////////////////
// Ordered dither stage, one cycle of latency
// Bias add and 5-bit level per lane
// Bayer offset and saturation to 4 bits
// Output register held under back-pressure
//////////////////////////////////////////////////
`timescale 1ns/1ps

module bayer_dithering (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      accept,
    input  logic [epd_pkg::lanes*epd_pkg::pix_w-1:0]  pix_data,
    input  epd_pkg::dither_mode_e                     mode,
    input  logic [7:0]                                bias,
    input  logic [1:0]                                y_phase,
    input  logic                                      line_last,
    input  logic                                      frame_last,
    input  logic                                      out_ready,
    output logic                                      stage_ready,
    output logic                                      out_valid,
    output logic [epd_pkg::lanes*epd_pkg::lvl_w-1:0]  out_data,
    output logic                                      out_line_end,
    output logic                                      out_frame_end
);
    import epd_pkg::*;

    logic [lanes*lvl_w-1:0] dith_data;

    // Adds the signed matrix offset when enabled and clamps to 0..15
    function automatic logic [lvl_w-1:0] sat_level(
        input logic [lvl_w:0]   level,
        input logic [3:0]       idx,
        input logic             use_bayer
    );
        logic signed [6:0] sum;
        sum = signed'({2'b00, level});
        if (use_bayer) begin
            sum = sum + signed'({3'b000, idx}) - 7'sd8;
        end
        if (sum < 0) begin
            return '0;
        end else if (sum > 7'sd15) begin
            return '1;
        end
        return sum[lvl_w-1:0];
    endfunction

    // Lane 0 sits in the top bits of both buses
    for (genvar k = 0; k < lanes; k++) begin : g_lane
        logic [pix_w:0] biased;

        assign biased = {1'b0, pix_data[pix_w*(lanes-k)-1 -: pix_w]} + {1'b0, bias};
        assign dith_data[lvl_w*(lanes-k)-1 -: lvl_w] =
            sat_level(biased[pix_w -: lvl_w+1], bayer4[y_phase][k], mode == mode_bayer);
    end

    // Room when empty or when the held group leaves this cycle
    assign stage_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid     <= 1'b0;
            out_line_end  <= 1'b0;
            out_frame_end <= 1'b0;
        end else if (accept) begin
            out_valid     <= 1'b1;
            out_line_end  <= line_last;
            out_frame_end <= line_last && frame_last;
        end else if (out_ready) begin
            out_valid     <= 1'b0;
            out_line_end  <= 1'b0;
            out_frame_end <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= dith_data;
        end
    end

endmodule

/* verilog/scan_counter.sv */
//////////////////////////////////////////////////
// Group and line position counters
// Line phase for the dither matrix row
// Last-group and last-line flags
//////////////////////////////////////////////////
`timescale 1ns/1ps

module scan_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      accept,
    input  logic [epd_pkg::dim_w-1:0] width,
    input  logic [epd_pkg::dim_w-1:0] height,
    output logic [1:0]                y_phase,
    output logic                      line_last,
    output logic                      frame_last
);
    import epd_pkg::*;

    logic [dim_w-1:0] grp_cnt;
    logic [dim_w-1:0] line_cnt;

    // Width and height hold the count minus one
    assign line_last  = (grp_cnt == width);
    assign frame_last = (line_cnt == height);
    assign y_phase    = line_cnt[1:0];

    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            grp_cnt  <= '0;
            line_cnt <= '0;
        end else if (accept) begin
            if (line_last) begin
                grp_cnt <= '0;
                // Wrap at the end of the frame so a following frame starts clean
                line_cnt <= frame_last ? '0 : line_cnt + 1'b1;
            end else begin
                grp_cnt <= grp_cnt + 1'b1;
            end
        end
    end

endmodule

/* verilog/frame_sequencer.sv */
//////////////////////////////////////////////////
// Frame control FSM for the dither stage
// Gates the input handshake per line
// Inserts a one-cycle gap between lines
//////////////////////////////////////////////////
`timescale 1ns/1ps

module frame_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic pix_valid,
    input  logic stage_ready,
    input  logic line_last,
    input  logic frame_last,
    output logic pix_ready,
    output logic accept,
    output logic busy,
    output logic frame_done
);
    import epd_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;

    // Input is only taken inside a line and when the output register has room
    assign pix_ready  = (state == st_line) && stage_ready;
    assign accept     = pix_valid && pix_ready;
    assign busy       = (state != st_idle);
    assign frame_done = (state == st_done);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_nxt = st_line;
                end
            end
            st_line: begin
                if (accept && line_last) begin
                    state_nxt = frame_last ? st_done : st_gap;
                end
            end
            // Gap and done each last a single cycle
            st_gap:  state_nxt = st_line;
            st_done: state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

/* verilog/dither_csr.sv */
//////////////////////////////////////////////////
// APB register block for the dither stage
// Control, bias, frame size and status registers
// Start pulse and finished-frame counter
//////////////////////////////////////////////////
`timescale 1ns/1ps

module dither_csr (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [11:0]               paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      busy,
    input  logic                      frame_done,
    output logic                      start,
    output epd_pkg::dither_mode_e     mode,
    output logic [7:0]                bias,
    output logic [epd_pkg::dim_w-1:0] width,
    output logic [epd_pkg::dim_w-1:0] height
);
    import epd_pkg::*;

    logic       access;
    logic       addr_hit;
    logic       wr_status;
    logic       wr_en;
    logic [7:0] frame_cnt;

    // Every access completes in its first access-phase cycle
    assign pready = 1'b1;

    assign access = psel && penable;

    always_comb begin
        case (paddr)
            addr_ctrl, addr_bias, addr_width, addr_height, addr_status: addr_hit = 1'b1;
            default: addr_hit = 1'b0;
        endcase
    end

    // Status is read only, so a write there is an error
    assign wr_status = pwrite && (paddr == addr_status);
    assign pslverr   = access && (!addr_hit || wr_status);
    assign wr_en     = access && pwrite && addr_hit && !wr_status;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start  <= 1'b0;
            mode   <= mode_bypass;
            bias   <= bias_default;
            width  <= '0;
            height <= '0;
        end else begin
            // A start request while a frame runs is dropped
            start <= wr_en && (paddr == addr_ctrl) && pwdata[0] && !busy;
            if (wr_en) begin
                case (paddr)
                    addr_ctrl:   mode   <= dither_mode_e'(pwdata[1]);
                    addr_bias:   bias   <= pwdata[7:0];
                    addr_width:  width  <= pwdata[dim_w-1:0];
                    addr_height: height <= pwdata[dim_w-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Wraps after 255 frames
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (frame_done) begin
            frame_cnt <= frame_cnt + 8'd1;
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            addr_ctrl:   prdata[1]         = mode;
            addr_bias:   prdata[7:0]       = bias;
            addr_width:  prdata[dim_w-1:0] = width;
            addr_height: prdata[dim_w-1:0] = height;
            addr_status: begin
                prdata[0]    = busy;
                prdata[15:8] = frame_cnt;
            end
            default: prdata = '0;
        endcase
    end

endmodule

/* verilog/epd_pkg.sv */
//////////////////////////////////////////////////
// Shared definitions for the e-paper dither stage
// Pixel, level and frame-size widths
// APB register map and reset defaults
// 4x4 Bayer index matrix
// Dither mode and sequencer state enums
//////////////////////////////////////////////////
package epd_pkg;

    // Datapath widths
    localparam int pix_w = 8;
    localparam int lvl_w = 4;
    localparam int lanes = 4;
    localparam int dim_w = 10;

    localparam logic [7:0] bias_default = 8'd10;

    // Register word addresses
    localparam logic [11:0] addr_ctrl   = 12'h000;
    localparam logic [11:0] addr_bias   = 12'h004;
    localparam logic [11:0] addr_width  = 12'h008;
    localparam logic [11:0] addr_height = 12'h00C;
    localparam logic [11:0] addr_status = 12'h010;

    // Ordered dither indices, row is line phase and column is lane
    // The applied offset is the index minus 8
    localparam logic [0:3][0:3][3:0] bayer4 = '{
        '{4'd0,  4'd8,  4'd2,  4'd10},
        '{4'd12, 4'd4,  4'd14, 4'd6},
        '{4'd3,  4'd11, 4'd1,  4'd9},
        '{4'd15, 4'd7,  4'd13, 4'd5}
    };

    typedef enum logic {
        mode_bypass = 1'b0,
        mode_bayer  = 1'b1
    } dither_mode_e;

    typedef enum logic [1:0] {
        st_idle,
        st_line,
        st_gap,
        st_done
    } seq_state_e;

endpackage
